/* flist.f */
+incdir+tests
source/decode_pkg.sv
source/uop_pkg.sv
source/fetch_bus.sv
source/fetch_fsm.sv
source/opcode_decoder.sv
source/micro_sequencer.sv
source/fetch_decode_top.sv
tests/tb_fetch_decode.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_decode \
  -f flist.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All checks passed" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

/* source/decode_pkg.sv */
package decode_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [19:0] addr_t;
  typedef logic [3:0]  reg_idx_t;   // ax cx dx bx sp bp si di, 8..15 none

  typedef enum logic [2:0]
  {
    st_opcode,
    st_modrm,
    st_offset,
    st_immed,
    st_execute,
    st_halted
  } fetch_state_e;

  typedef enum logic [3:0]
  {
    cls_nop,
    cls_halt,
    cls_mov_imm,
    cls_mov_rm,
    cls_push,
    cls_pop,
    cls_jcc,
    cls_jmp,
    cls_movs,
    cls_stos
  } instr_class_e;

  localparam byte_t op_rep       = 8'hf3;   // f2 matches on bits 7:1
  localparam byte_t op_nop       = 8'h90;
  localparam byte_t op_hlt       = 8'hf4;
  localparam byte_t op_jmp_near  = 8'he9;
  localparam byte_t op_jmp_short = 8'heb;

  // direct address form of modrm
  localparam logic [1:0] mod_direct = 2'b00;
  localparam logic [2:0] rm_direct  = 3'b110;

endpackage

/* source/fetch_bus.sv */
`timescale 1ns/1ps

module fetch_bus (
  input  logic              clk,
  input  logic              rst,
  input  decode_pkg::word_t cs_i,
  input  logic              fetch_req_i,
  input  decode_pkg::byte_t wb_dat_i,
  input  logic              wb_ack_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output decode_pkg::addr_t wb_adr_o,
  output logic              byte_valid_o,
  output decode_pkg::byte_t byte_data_o
);

  decode_pkg::word_t ip;
  logic              busy;

  // busy drops on ack, so stb is low for at least one cycle between reads
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ip   <= '0;
      busy <= 1'b0;
    end
    else if (busy)
    begin
      if (wb_ack_i)
      begin
        busy <= 1'b0;
        ip   <= ip + 16'd1;
      end
    end
    else if (fetch_req_i)
    begin
      busy <= 1'b1;
    end
  end

  assign wb_cyc_o     = busy;
  assign wb_stb_o     = busy;
  assign wb_adr_o     = {cs_i, 4'h0} + {4'h0, ip};   // cs * 16 + ip
  assign byte_valid_o = busy && wb_ack_i;
  assign byte_data_o  = wb_dat_i;

  a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

/* source/fetch_decode_top.sv */
`timescale 1ns/1ps

module fetch_decode_top (
  input  logic                 clk,
  input  logic                 rst,
  input  decode_pkg::word_t    cs_i,
  input  decode_pkg::byte_t    wb_dat_i,
  input  logic                 wb_ack_i,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output decode_pkg::addr_t    wb_adr_o,
  input  logic                 cx_zero_i,
  input  logic                 uop_ready_i,
  output logic                 uop_valid_o,
  output uop_pkg::uop_kind_e   uop_kind_o,
  output decode_pkg::reg_idx_t uop_dst_o,
  output decode_pkg::reg_idx_t uop_src_o,
  output decode_pkg::reg_idx_t uop_base_o,
  output decode_pkg::reg_idx_t uop_index_o,
  output logic                 uop_word_o,
  output decode_pkg::word_t    uop_imm_o,
  output decode_pkg::word_t    uop_off_o,
  output logic                 uop_last_o
);

  logic                     byte_valid, fetch_req, rep, seq_start, seq_done, halt;
  logic                     need_modrm, need_off, off_word, need_imm, imm_word;
  logic                     mem_form, word;
  decode_pkg::byte_t        byte_data, opcode, modrm;
  decode_pkg::word_t        off, imm;
  decode_pkg::instr_class_e cls;
  decode_pkg::reg_idx_t     dst, src, ea_base, ea_index;

  fetch_bus fetch_bus_inst (
    .clk          (clk),
    .rst          (rst),
    .cs_i         (cs_i),
    .fetch_req_i  (fetch_req),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data)
  );

  fetch_fsm fetch_fsm_inst (
    .clk          (clk),
    .rst          (rst),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .need_modrm_i (need_modrm),
    .need_off_i   (need_off),
    .off_word_i   (off_word),
    .need_imm_i   (need_imm),
    .imm_word_i   (imm_word),
    .seq_done_i   (seq_done),
    .halt_i       (halt),
    .fetch_req_o  (fetch_req),
    .opcode_o     (opcode),
    .modrm_o      (modrm),
    .off_o        (off),
    .imm_o        (imm),
    .rep_o        (rep),
    .seq_start_o  (seq_start)
  );

  opcode_decoder opcode_decoder_inst (
    .opcode_i     (opcode),
    .modrm_i      (modrm),
    .need_modrm_o (need_modrm),
    .need_off_o   (need_off),
    .off_word_o   (off_word),
    .need_imm_o   (need_imm),
    .imm_word_o   (imm_word),
    .class_o      (cls),
    .mem_form_o   (mem_form),
    .word_o       (word),
    .dst_o        (dst),
    .src_o        (src),
    .ea_base_o    (ea_base),
    .ea_index_o   (ea_index)
  );

  micro_sequencer micro_sequencer_inst (
    .clk          (clk),
    .rst          (rst),
    .seq_start_i  (seq_start),
    .class_i      (cls),
    .mem_form_i   (mem_form),
    .word_i       (word),
    .rep_i        (rep),
    .cx_zero_i    (cx_zero_i),
    .opcode_dir_i (opcode[1]),
    .dst_i        (dst),
    .src_i        (src),
    .ea_base_i    (ea_base),
    .ea_index_i   (ea_index),
    .off_i        (off),
    .imm_i        (imm),
    .uop_ready_i  (uop_ready_i),
    .seq_done_o   (seq_done),
    .halt_o       (halt),
    .uop_valid_o  (uop_valid_o),
    .uop_kind_o   (uop_kind_o),
    .uop_dst_o    (uop_dst_o),
    .uop_src_o    (uop_src_o),
    .uop_base_o   (uop_base_o),
    .uop_index_o  (uop_index_o),
    .uop_word_o   (uop_word_o),
    .uop_imm_o    (uop_imm_o),
    .uop_off_o    (uop_off_o),
    .uop_last_o   (uop_last_o)
  );

endmodule

/* source/fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm (
  input  logic              clk,
  input  logic              rst,
  input  logic              byte_valid_i,
  input  decode_pkg::byte_t byte_data_i,
  input  logic              need_modrm_i,
  input  logic              need_off_i,
  input  logic              off_word_i,
  input  logic              need_imm_i,
  input  logic              imm_word_i,
  input  logic              seq_done_i,
  input  logic              halt_i,
  output logic              fetch_req_o,
  output decode_pkg::byte_t opcode_o,
  output decode_pkg::byte_t modrm_o,
  output decode_pkg::word_t off_o,
  output decode_pkg::word_t imm_o,
  output logic              rep_o,
  output logic              seq_start_o
);

  decode_pkg::fetch_state_e state, nxt;
  decode_pkg::fetch_state_e from_opcode, after_modrm, after_off;
  decode_pkg::byte_t        opcode_l, modrm_l;
  logic                     prefix, hi_byte, wide_lo;

  function automatic decode_pkg::word_t low_byte(decode_pkg::byte_t b, logic wide);
    return wide ? {8'h00, b} : {{8{b[7]}}, b};   // sign extend short fields
  endfunction

  assign prefix      = byte_data_i[7:1] == decode_pkg::op_rep[7:1];
  assign opcode_o    = (state == decode_pkg::st_opcode) ? byte_data_i : opcode_l;
  assign modrm_o     = (state == decode_pkg::st_modrm) ? byte_data_i : modrm_l;
  assign fetch_req_o = state inside {decode_pkg::st_opcode, decode_pkg::st_modrm,
                                     decode_pkg::st_offset, decode_pkg::st_immed};

  assign after_off   = need_imm_i ? decode_pkg::st_immed : decode_pkg::st_execute;
  assign after_modrm = need_off_i ? decode_pkg::st_offset : after_off;
  assign from_opcode = need_modrm_i ? decode_pkg::st_modrm : after_modrm;

  // first byte of a two byte field
  assign wide_lo = !hi_byte && ((state == decode_pkg::st_offset && off_word_i)
                             || (state == decode_pkg::st_immed && imm_word_i));

  always_comb
  begin
    nxt = state;
    if (halt_i)
      nxt = decode_pkg::st_halted;
    else if (seq_done_i)
      nxt = decode_pkg::st_opcode;
    else if (byte_valid_i && !wide_lo)
    begin
      case (state)
        decode_pkg::st_opcode: nxt = prefix ? decode_pkg::st_opcode : from_opcode;
        decode_pkg::st_modrm:  nxt = after_modrm;
        decode_pkg::st_offset: nxt = after_off;
        decode_pkg::st_immed:  nxt = decode_pkg::st_execute;
        default:               nxt = state;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= decode_pkg::st_opcode;
      seq_start_o <= 1'b0;
      hi_byte     <= 1'b0;
      rep_o       <= 1'b0;
    end
    else
    begin
      state       <= nxt;
      seq_start_o <= nxt == decode_pkg::st_execute && state != decode_pkg::st_execute;
      if (byte_valid_i)
        hi_byte <= wide_lo;
      if (seq_done_i)
        rep_o <= 1'b0;
      else if (byte_valid_i && state == decode_pkg::st_opcode && prefix)
        rep_o <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_valid_i)
    begin
      case (state)
        decode_pkg::st_opcode:
        begin
          opcode_l <= byte_data_i;
          off_o    <= '0;
          imm_o    <= '0;
        end
        decode_pkg::st_modrm:  modrm_l <= byte_data_i;
        decode_pkg::st_offset:
          off_o <= hi_byte ? {byte_data_i, off_o[7:0]} : low_byte(byte_data_i, off_word_i);
        decode_pkg::st_immed:
          imm_o <= hi_byte ? {byte_data_i, imm_o[7:0]} : low_byte(byte_data_i, imm_word_i);
        default: ;
      endcase
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state inside {decode_pkg::st_opcode, decode_pkg::st_modrm, decode_pkg::st_offset,
                  decode_pkg::st_immed, decode_pkg::st_execute, decode_pkg::st_halted});

endmodule

/* source/micro_sequencer.sv */
`timescale 1ns/1ps

module micro_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     seq_start_i,
  input  decode_pkg::instr_class_e class_i,
  input  logic                     mem_form_i,
  input  logic                     word_i,
  input  logic                     rep_i,
  input  logic                     cx_zero_i,
  input  logic                     opcode_dir_i,
  input  decode_pkg::reg_idx_t     dst_i,
  input  decode_pkg::reg_idx_t     src_i,
  input  decode_pkg::reg_idx_t     ea_base_i,
  input  decode_pkg::reg_idx_t     ea_index_i,
  input  decode_pkg::word_t        off_i,
  input  decode_pkg::word_t        imm_i,
  input  logic                     uop_ready_i,
  output logic                     seq_done_o,
  output logic                     halt_o,
  output logic                     uop_valid_o,
  output uop_pkg::uop_kind_e       uop_kind_o,
  output decode_pkg::reg_idx_t     uop_dst_o,
  output decode_pkg::reg_idx_t     uop_src_o,
  output decode_pkg::reg_idx_t     uop_base_o,
  output decode_pkg::reg_idx_t     uop_index_o,
  output logic                     uop_word_o,
  output decode_pkg::word_t        uop_imm_o,
  output decode_pkg::word_t        uop_off_o,
  output logic                     uop_last_o
);

  uop_pkg::step_t     step, next_step, nsteps;
  uop_pkg::uop_kind_e next_kind;
  logic               rep_str, again, skip_now, skip_q, xfer, load;

  // inputs hold steady while the fetch side sits in execute
  function automatic uop_pkg::uop_kind_e kind_at(uop_pkg::step_t s);
    uop_pkg::uop_kind_e k;
    k = uop_pkg::uop_nop;
    if (rep_str && s == nsteps - 3'd1)
      k = uop_pkg::uop_dec_cx;   // closes each rep pass
    else
    begin
      case (class_i)
        decode_pkg::cls_halt:    k = uop_pkg::uop_halt;
        decode_pkg::cls_mov_imm: k = uop_pkg::uop_load_imm;
        decode_pkg::cls_mov_rm:
          k = !mem_form_i ? uop_pkg::uop_move
            : (s == 3'd0) ? uop_pkg::uop_addr
            : (opcode_dir_i ? uop_pkg::uop_load : uop_pkg::uop_store);
        decode_pkg::cls_push: k = (s == 3'd0) ? uop_pkg::uop_dec_sp : uop_pkg::uop_store;
        decode_pkg::cls_pop:  k = (s == 3'd0) ? uop_pkg::uop_load : uop_pkg::uop_inc_sp;
        decode_pkg::cls_jcc:  k = uop_pkg::uop_branch;
        decode_pkg::cls_jmp:  k = uop_pkg::uop_jump;
        decode_pkg::cls_movs:
          k = (s == 3'd0) ? uop_pkg::uop_load
            : (s == 3'd1) ? uop_pkg::uop_store : uop_pkg::uop_advance;
        decode_pkg::cls_stos: k = (s == 3'd0) ? uop_pkg::uop_store : uop_pkg::uop_advance;
        default:              k = uop_pkg::uop_nop;
      endcase
    end
    return k;
  endfunction

  assign rep_str  = rep_i && (class_i == decode_pkg::cls_movs
                           || class_i == decode_pkg::cls_stos);
  assign nsteps   = uop_pkg::class_steps[class_i]
                  + uop_pkg::step_t'(class_i == decode_pkg::cls_mov_rm && mem_form_i)
                  + uop_pkg::step_t'(rep_str);
  assign again    = rep_str && !cx_zero_i;
  assign skip_now = rep_str && cx_zero_i;   // cx already zero, nothing to do
  assign xfer     = uop_valid_o && uop_ready_i;
  assign load     = seq_start_i || xfer;

  assign next_step = (seq_start_i || uop_last_o) ? 3'd0 : step + 3'd1;
  assign next_kind = kind_at(next_step);

  assign seq_done_o = (xfer && uop_last_o && !again) || skip_q;
  assign halt_o     = xfer && uop_kind_o == uop_pkg::uop_halt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      uop_valid_o <= 1'b0;
      skip_q      <= 1'b0;
      step        <= '0;
    end
    else
    begin
      skip_q <= seq_start_i && skip_now;
      if (load)
        step <= next_step;
      if (seq_start_i)
        uop_valid_o <= !skip_now;
      else if (xfer && uop_last_o && !again)
        uop_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      uop_kind_o  <= next_kind;
      uop_dst_o   <= (next_kind == uop_pkg::uop_dec_sp || next_kind == uop_pkg::uop_inc_sp)
                     ? uop_pkg::reg_sp
                     : (next_kind == uop_pkg::uop_dec_cx) ? uop_pkg::reg_cx : dst_i;
      uop_src_o   <= src_i;
      uop_base_o  <= ea_base_i;
      uop_index_o <= ea_index_i;
      uop_word_o  <= word_i;
      uop_imm_o   <= imm_i;
      uop_off_o   <= off_i;
      uop_last_o  <= next_step == nsteps - 3'd1;
    end
  end

  a_hold_uop: assert property (@(posedge clk) disable iff (rst)
    uop_valid_o && !uop_ready_i |=> uop_valid_o
      && $stable({uop_kind_o, uop_dst_o, uop_src_o, uop_base_o, uop_index_o,
                  uop_word_o, uop_imm_o, uop_off_o, uop_last_o}));

endmodule

/* source/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder (
  input  decode_pkg::byte_t        opcode_i,
  input  decode_pkg::byte_t        modrm_i,
  output logic                     need_modrm_o,
  output logic                     need_off_o,
  output logic                     off_word_o,
  output logic                     need_imm_o,
  output logic                     imm_word_o,
  output decode_pkg::instr_class_e class_o,
  output logic                     mem_form_o,
  output logic                     word_o,
  output decode_pkg::reg_idx_t     dst_o,
  output decode_pkg::reg_idx_t     src_o,
  output decode_pkg::reg_idx_t     ea_base_o,
  output decode_pkg::reg_idx_t     ea_index_o
);

  logic [1:0]           mod;
  logic [2:0]           regm, rm;
  logic                 direct, dir;
  decode_pkg::reg_idx_t rm_base, rm_index;

  assign mod    = modrm_i[7:6];
  assign regm   = modrm_i[5:3];
  assign rm     = modrm_i[2:0];
  assign dir    = opcode_i[1];   // 1 means reg is the destination
  assign direct = mod == decode_pkg::mod_direct && rm == decode_pkg::rm_direct;

  // bx+si bx+di bp+si bp+di si di bp/disp bx
  assign rm_base = !rm[2] ? (rm[1] ? uop_pkg::reg_bp : uop_pkg::reg_bx)
                 : !rm[1] ? uop_pkg::reg_none
                 : rm[0]  ? uop_pkg::reg_bx
                 : direct ? uop_pkg::reg_none : uop_pkg::reg_bp;
  assign rm_index = (rm[2] && rm[1]) ? uop_pkg::reg_none
                  : (rm[0] ? uop_pkg::reg_di : uop_pkg::reg_si);

  always_comb
  begin
    need_modrm_o = 1'b0;
    need_off_o   = 1'b0;
    off_word_o   = 1'b0;
    need_imm_o   = 1'b0;
    imm_word_o   = 1'b0;
    class_o      = decode_pkg::cls_nop;
    mem_form_o   = 1'b0;
    word_o       = opcode_i[0];
    dst_o        = uop_pkg::reg_none;
    src_o        = uop_pkg::reg_none;
    ea_base_o    = uop_pkg::reg_none;
    ea_index_o   = uop_pkg::reg_none;
    casez (opcode_i)
      decode_pkg::op_nop: class_o = decode_pkg::cls_nop;
      decode_pkg::op_hlt: class_o = decode_pkg::cls_halt;
      8'b1011_????:
      begin
        class_o    = decode_pkg::cls_mov_imm;
        need_imm_o = 1'b1;
        imm_word_o = opcode_i[3];
        word_o     = opcode_i[3];
        dst_o      = {1'b0, opcode_i[2:0]};
      end
      8'b1000_10??:
      begin
        class_o      = decode_pkg::cls_mov_rm;
        need_modrm_o = 1'b1;
        need_off_o   = direct || ^mod;
        off_word_o   = direct || mod[1];
        dst_o        = {1'b0, dir ? regm : rm};
        src_o        = {1'b0, dir ? rm : regm};
        if (mod != 2'b11)
        begin
          mem_form_o = 1'b1;
          ea_base_o  = rm_base;
          ea_index_o = rm_index;
          if (dir)
            src_o = uop_pkg::reg_none;
          else
            dst_o = uop_pkg::reg_none;
        end
      end
      8'b0101_0???:
      begin
        class_o   = decode_pkg::cls_push;
        word_o    = 1'b1;
        src_o     = {1'b0, opcode_i[2:0]};
        ea_base_o = uop_pkg::reg_sp;
      end
      8'b0101_1???:
      begin
        class_o   = decode_pkg::cls_pop;
        word_o    = 1'b1;
        dst_o     = {1'b0, opcode_i[2:0]};
        ea_base_o = uop_pkg::reg_sp;
      end
      8'b0111_????:
      begin
        class_o    = decode_pkg::cls_jcc;
        need_imm_o = 1'b1;
        src_o      = opcode_i[3:0];   // condition code
      end
      decode_pkg::op_jmp_near, decode_pkg::op_jmp_short:
      begin
        class_o    = decode_pkg::cls_jmp;
        need_imm_o = 1'b1;
        imm_word_o = opcode_i == decode_pkg::op_jmp_near;
        word_o     = 1'b1;
      end
      8'b1010_010?:
      begin
        class_o = decode_pkg::cls_movs;
        src_o   = uop_pkg::reg_si;
        dst_o   = uop_pkg::reg_di;
      end
      8'b1010_101?:
      begin
        class_o = decode_pkg::cls_stos;
        src_o   = uop_pkg::reg_ax;
        dst_o   = uop_pkg::reg_di;
      end
      default: class_o = decode_pkg::cls_nop;
    endcase
  end

endmodule

/* source/uop_pkg.sv */
package uop_pkg;

  typedef enum logic [3:0]
  {
    uop_nop,
    uop_halt,
    uop_load_imm,
    uop_move,
    uop_addr,
    uop_load,
    uop_store,
    uop_dec_sp,
    uop_inc_sp,
    uop_branch,
    uop_jump,
    uop_advance,
    uop_dec_cx
  } uop_kind_e;

  typedef logic [2:0] step_t;

  localparam decode_pkg::reg_idx_t reg_ax   = 4'd0;
  localparam decode_pkg::reg_idx_t reg_cx   = 4'd1;
  localparam decode_pkg::reg_idx_t reg_bx   = 4'd3;
  localparam decode_pkg::reg_idx_t reg_sp   = 4'd4;
  localparam decode_pkg::reg_idx_t reg_bp   = 4'd5;
  localparam decode_pkg::reg_idx_t reg_si   = 4'd6;
  localparam decode_pkg::reg_idx_t reg_di   = 4'd7;
  localparam decode_pkg::reg_idx_t reg_none = 4'd12;

  // indexed by instr_class_e, memory form and rep add one step each
  localparam step_t class_steps [10] = '{
    3'd1,   // nop
    3'd1,   // halt
    3'd1,   // mov_imm
    3'd1,   // mov_rm
    3'd2,   // push
    3'd2,   // pop
    3'd1,   // jcc
    3'd1,   // jmp
    3'd3,   // movs
    3'd2    // stos
  };

endpackage

/* tests/tb_checks.svh */
int checks [7] = '{default: 0};
int errs [7] = '{default: 0};

function automatic string test_name(input int t);
  case (t)
    0:       return "reset_idle";
    1:       return "fetch_address";
    2:       return "halt_stops_bus";
    3:       return "simple_classes";
    4:       return "mov_rm_forms";
    5:       return "string_ops";
    default: return "stream_integrity";
  endcase
endfunction

task automatic report_mismatch(input int t, input logic [63:0] expv, input logic [63:0] actv);
  $display("Error %s: expected %h actual %h", test_name(t), expv, actv);
  errs[t]++;
endtask

task automatic note_failure(input int t, input string msg);
  $display("%s: %s", test_name(t), msg);
  errs[t]++;
endtask

a_reset_idle: assert property (@(posedge clk) rst && cycle > 0
  |-> !wb_cyc_o && !wb_stb_o && !uop_valid_o)
  else note_failure(0, "bus or uop valid active during reset");

a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
  wb_stb_o && wb_ack_i |-> wb_adr_o == exp_adr)
  else report_mismatch(1, $sampled(exp_adr), $sampled(wb_adr_o));

a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
  wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o))
  else note_failure(1, "stb or address changed before ack");

a_halt_quiet: assert property (@(posedge clk) disable iff (rst) halted |-> !wb_cyc_o)
  else note_failure(2, "bus cycle started after halt");

a_no_extra: assert property (@(posedge clk) disable iff (rst)
  uop_valid_o && uop_ready_i |-> exp_idx < exp_count)
  else note_failure(6, "micro-operation beyond the expected stream");

a_uop_match: assert property (@(posedge clk) disable iff (rst)
  uop_valid_o && uop_ready_i && exp_idx < exp_count |-> got == exp_head)
  else report_mismatch($sampled(exp_test_cur), $sampled(exp_head), $sampled(got));

a_uop_hold: assert property (@(posedge clk) disable iff (rst)
  uop_valid_o && !uop_ready_i |=> uop_valid_o && $stable(got))
  else note_failure(6, "micro-operation changed while held");

/* tests/tb_fetch_decode.sv */
`timescale 1ns/1ps

module tb_fetch_decode;

  typedef logic [53:0] uop_bits_t;   // kind dst src base index word imm off last

  localparam decode_pkg::reg_idx_t no_reg = uop_pkg::reg_none;

  logic                 clk, rst, wb_ack_i, wb_cyc_o, wb_stb_o, cx_zero_i, uop_ready_i;
  logic                 uop_valid_o, uop_word_o, uop_last_o, halted, xfer_q, ack_given;
  logic                 in_run;
  decode_pkg::word_t    cs_i, uop_imm_o, uop_off_o;
  decode_pkg::byte_t    wb_dat_i;
  decode_pkg::addr_t    wb_adr_o, exp_adr;
  uop_pkg::uop_kind_e   uop_kind_o, kind_q;
  decode_pkg::reg_idx_t uop_dst_o, uop_src_o, uop_base_o, uop_index_o;
  decode_pkg::byte_t    prog [40];
  int                   cx_at [40];
  uop_bits_t            exp_mem [128];
  int                   exp_test [128];
  uop_bits_t            got, exp_head;
  int                   exp_count, exp_idx, exp_test_cur, cycle, limit, ack_count;
  int                   dcx, preset, waitc, ofs, r, total_checks, total_errs;
  logic [15:0]          lfsr = 16'd35;

  fetch_decode_top fetch_decode_top_inst (.*);

  assign got          = {uop_kind_o, uop_dst_o, uop_src_o, uop_base_o, uop_index_o,
                         uop_word_o, uop_imm_o, uop_off_o, uop_last_o};
  assign exp_head     = exp_mem[exp_idx];
  assign exp_test_cur = exp_test[exp_idx];
  assign exp_adr      = {cs_i, 4'h0} + 20'(ack_count);

  `include "tb_checks.svh"

  function automatic int random_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  function automatic decode_pkg::byte_t fetch_byte(input decode_pkg::addr_t a);
    int o;
    o = int'(a) - int'({cs_i, 4'h0});
    if (o >= 0 && o < 40)
      return prog[o];
    return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};   // outside the program
  endfunction

  task automatic add_uop(input int t, input uop_pkg::uop_kind_e k,
                         input decode_pkg::reg_idx_t d, input decode_pkg::reg_idx_t s,
                         input decode_pkg::reg_idx_t b, input decode_pkg::reg_idx_t x,
                         input logic w, input decode_pkg::word_t imm,
                         input decode_pkg::word_t off, input logic last);
    exp_mem[exp_count]  = {k, d, s, b, x, w, imm, off, last};
    exp_test[exp_count] = t;
    exp_count++;
  endtask

  task automatic single_uop(input int t, input uop_pkg::uop_kind_e k,
                            input decode_pkg::reg_idx_t d, input decode_pkg::reg_idx_t s,
                            input logic w, input decode_pkg::word_t imm);
    add_uop(t, k, d, s, no_reg, no_reg, w, imm, 16'h0, 1'b1);
  endtask

  task automatic mem_rm_uops(input logic ld, input decode_pkg::reg_idx_t d,
                             input decode_pkg::reg_idx_t s, input decode_pkg::reg_idx_t b,
                             input decode_pkg::reg_idx_t x, input logic w,
                             input decode_pkg::word_t off);
    add_uop(4, uop_pkg::uop_addr, d, s, b, x, w, 16'h0, off, 1'b0);
    add_uop(4, ld ? uop_pkg::uop_load : uop_pkg::uop_store, d, s, b, x, w, 16'h0, off, 1'b1);
  endtask

  task automatic string_uops(input logic movs, input logic w, input int passes,
                             input logic rep);
    decode_pkg::reg_idx_t s;
    s = movs ? 4'd6 : 4'd0;   // si for movs, ax for stos
    for (int p = 0; p < passes; p++)
    begin
      if (movs)
        add_uop(5, uop_pkg::uop_load, 4'd7, s, no_reg, no_reg, w, 16'h0, 16'h0, 1'b0);
      add_uop(5, uop_pkg::uop_store, 4'd7, s, no_reg, no_reg, w, 16'h0, 16'h0, 1'b0);
      add_uop(5, uop_pkg::uop_advance, 4'd7, s, no_reg, no_reg, w, 16'h0, 16'h0, !rep);
      if (rep)
        add_uop(5, uop_pkg::uop_dec_cx, 4'd1, s, no_reg, no_reg, w, 16'h0, 16'h0, 1'b1);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    cs_i = 16'h1234;
    wb_dat_i = 8'h00;
    wb_ack_i = 1'b0;
    cx_zero_i = 1'b1;
    uop_ready_i = 1'b0;
    halted = 1'b0;
    xfer_q = 1'b0;
    ack_given = 1'b0;
    kind_q = uop_pkg::uop_nop;
    {exp_count, exp_idx, cycle, ack_count, dcx, preset} = '0;
    waitc = -1;
    prog = '{8'hb0, 8'h85, 8'hbb, 8'h34, 8'h12, 8'h90, 8'h0f, 8'h53, 8'h59, 8'h74,
             8'hf0, 8'heb, 8'h05, 8'he9, 8'h00, 8'h80, 8'h89, 8'hd8, 8'h8b, 8'h47,
             8'hfc, 8'h88, 8'h8a, 8'h10, 8'h20, 8'h8a, 8'h36, 8'h78, 8'h56, 8'h8b,
             8'h00, 8'hf3, 8'ha4, 8'hf2, 8'hab, 8'hf3, 8'haa, 8'ha5, 8'haa, 8'hf4};
    cx_at = '{default: -1};
    cx_at[32] = 2;   // rep passes before cx reads zero
    cx_at[34] = 1;
    cx_at[36] = 0;
    single_uop(3, uop_pkg::uop_load_imm, 4'd0, no_reg, 1'b0, 16'hff85);
    single_uop(3, uop_pkg::uop_load_imm, 4'd3, no_reg, 1'b1, 16'h1234);
    single_uop(3, uop_pkg::uop_nop, no_reg, no_reg, 1'b0, 16'h0);
    single_uop(3, uop_pkg::uop_nop, no_reg, no_reg, 1'b1, 16'h0);
    add_uop(3, uop_pkg::uop_dec_sp, 4'd4, 4'd3, 4'd4, no_reg, 1'b1, 16'h0, 16'h0, 1'b0);
    add_uop(3, uop_pkg::uop_store, no_reg, 4'd3, 4'd4, no_reg, 1'b1, 16'h0, 16'h0, 1'b1);
    add_uop(3, uop_pkg::uop_load, 4'd1, no_reg, 4'd4, no_reg, 1'b1, 16'h0, 16'h0, 1'b0);
    add_uop(3, uop_pkg::uop_inc_sp, 4'd4, no_reg, 4'd4, no_reg, 1'b1, 16'h0, 16'h0, 1'b1);
    single_uop(3, uop_pkg::uop_branch, no_reg, 4'd4, 1'b0, 16'hfff0);   // jz
    single_uop(3, uop_pkg::uop_jump, no_reg, no_reg, 1'b1, 16'h0005);
    single_uop(3, uop_pkg::uop_jump, no_reg, no_reg, 1'b1, 16'h8000);
    add_uop(4, uop_pkg::uop_move, 4'd0, 4'd3, no_reg, no_reg, 1'b1, 16'h0, 16'h0, 1'b1);
    mem_rm_uops(1'b1, 4'd0, no_reg, 4'd3, no_reg, 1'b1, 16'hfffc);
    mem_rm_uops(1'b0, no_reg, 4'd1, 4'd5, 4'd6, 1'b0, 16'h2010);
    mem_rm_uops(1'b1, 4'd6, no_reg, no_reg, no_reg, 1'b0, 16'h5678);
    mem_rm_uops(1'b1, 4'd0, no_reg, 4'd3, 4'd6, 1'b1, 16'h0000);
    string_uops(1'b1, 1'b0, 2, 1'b1);
    string_uops(1'b0, 1'b1, 1, 1'b1);
    string_uops(1'b1, 1'b1, 1, 1'b0);
    string_uops(1'b0, 1'b0, 1, 1'b0);
    single_uop(3, uop_pkg::uop_halt, no_reg, no_reg, 1'b0, 16'h0);
    limit = 40 * 40 + 10 * exp_count;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    while (!(halted && exp_idx >= exp_count) && cycle < limit)
      @(posedge clk);
    repeat (20) @(posedge clk);   // bus must stay idle after halt
    if (cycle >= limit)
      note_failure(6, "timeout before the program finished");
    if (exp_idx != exp_count)
      report_mismatch(6, exp_count, exp_idx);
    total_checks = 0;
    total_errs = 0;
    for (int t = 0; t < 7; t++)
    begin
      $display("test %-16s checks %0d errors %0d", test_name(t), checks[t], errs[t]);
      total_checks += checks[t];
      total_errs += errs[t];
    end
    $display("total checks %0d errors %0d", total_checks, total_errs);
    if (total_errs == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      in_run = !rst;   // reset as seen at this edge
      cycle++;
      if (rst && cycle > 1)
        checks[0]++;
      if (!rst && ack_given)
      begin
        ack_count++;
        checks[1]++;
      end
      if (!rst && xfer_q)
      begin
        if (exp_idx < exp_count)
          checks[exp_test[exp_idx]]++;
        checks[6]++;
        if (kind_q == uop_pkg::uop_dec_cx)
          dcx++;
        if (kind_q == uop_pkg::uop_halt)
          halted = 1'b1;
        exp_idx++;
      end
      if (halted)
        checks[2]++;
      #1;
      if (in_run)
      begin
        if (wb_ack_i)
        begin
          wb_ack_i = 1'b0;
          waitc = -1;
        end
        else if (wb_stb_o)
        begin
          if (waitc < 0)
            waitc = random_bits(2);   // 0 to 3 wait cycles
          if (waitc == 0)
          begin
            wb_ack_i = 1'b1;
            wb_dat_i = fetch_byte(wb_adr_o);
            ofs = int'(wb_adr_o) - int'({cs_i, 4'h0});
            if (ofs >= 0 && ofs < 40 && cx_at[ofs] >= 0)
            begin
              preset = cx_at[ofs];
              dcx = 0;
            end
          end
          else
            waitc--;
        end
        do
          r = random_bits(2);
        while (r == 3);
        uop_ready_i = r != 0;
        cx_zero_i = dcx + int'(uop_valid_o && uop_kind_o == uop_pkg::uop_dec_cx) >= preset;
        ack_given = wb_ack_i;
        xfer_q = uop_valid_o && uop_ready_i;
        kind_q = uop_kind_o;
      end
    end
  end

endmodule
